// File: me_consts.svh
`ifndef ME_CONSTS_SVH
`define ME_CONSTS_SVH

// pixels per row, and rows per block
`define ME_MACRO_DIM 4

`define ME_PIX_W 8

// input register, abs difference and two adder tree stages
`define ME_PIPE_DEPTH 4

`define ME_CAND_W 4

`endif

// File: me_pkg.sv
`default_nettype none

`include "me_consts.svh"

package me_pkg;

    typedef logic [`ME_PIX_W-1:0] pixel_t;

    // one row of a block, pixel 0 in the low bits
    typedef struct packed {
        pixel_t [`ME_MACRO_DIM-1:0] pix;
    } pixel_row_t;

    // wide enough for a whole block of maximum differences (16 x 255 = 4080)
    typedef logic [$clog2(`ME_MACRO_DIM * `ME_MACRO_DIM * ((1 << `ME_PIX_W) - 1) + 1) - 1:0]
        sad_t;

    typedef struct packed {
        sad_t                  sad;       // SAD of the run that just finished
        sad_t                  best_sad;
        logic [`ME_CAND_W-1:0] best_idx;
    } me_result_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_RUN  = 2'b01,
        ST_DONE = 2'b10
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: controller_me.sv
`timescale 1ns/1ps
`default_nettype none

`include "me_consts.svh"

module controller_me
(
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic clear_best,
    output logic en_cpr,
    output logic en_spr,
    output logic acc_clear,
    output logic valid,
    output logic best_clear
);

    import me_pkg::*;

    localparam logic [3:0] LOAD_CYCLES = 4'(`ME_MACRO_DIM);
    localparam logic [3:0] RUN_LAST    = 4'(`ME_MACRO_DIM + `ME_PIPE_DEPTH - 1);

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic [3:0]  count;
    logic        start_ok;

    assign start_ok = (state == ST_IDLE) && start;   // a start while busy is simply dropped

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ST_IDLE:
            begin
                if (start)
                begin
                    next_state = ST_RUN;
                end
            end
            ST_RUN:
            begin
                if (count == RUN_LAST)   // rows loaded and the tree drained
                begin
                    next_state = ST_DONE;
                end
            end
            ST_DONE:
            begin
                next_state = ST_IDLE;
            end
            default:
            begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // counts only while running and sits at zero otherwise
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
        end
        else if (state == ST_RUN)
        begin
            count <= count + 4'd1;
        end
        else
        begin
            count <= '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            best_clear <= 1'b0;
        end
        else if (start_ok)
        begin
            best_clear <= clear_best;   // held for the whole run
        end
    end

    assign en_cpr    = (state == ST_RUN) && (count < LOAD_CYCLES);
    assign en_spr    = en_cpr;
    assign acc_clear = start_ok;
    assign valid     = (state == ST_DONE);

    // the done strobe comes only after the last loaded row has drained through the tree
    a_valid_not_loading: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> !$past(en_cpr, `ME_PIPE_DEPTH));

endmodule

`default_nettype wire

// File: sad_row_tree.sv
`timescale 1ns/1ps
`default_nettype none

`include "me_consts.svh"

module sad_row_tree
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en_cpr,
    input  logic              en_spr,
    input  me_pkg::pixel_row_t cur_row,
    input  me_pkg::pixel_row_t ref_row,
    output me_pkg::sad_t      row_sum,
    output logic              row_sum_valid
);

    import me_pkg::*;

    localparam int PAIRS = `ME_MACRO_DIM / 2;

    pixel_row_t                 cur_q;
    pixel_row_t                 ref_q;
    pixel_t [`ME_MACRO_DIM-1:0] diff_q;
    sad_t [PAIRS-1:0]           pair_q;
    logic                       in_valid;
    logic                       diff_valid;
    logic                       pair_valid;

    function automatic pixel_t abs_diff(input pixel_t a, input pixel_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    always_ff @(posedge clk)
    begin
        if (en_cpr)
        begin
            cur_q <= cur_row;
        end
        if (en_spr)
        begin
            ref_q <= ref_row;
        end
    end

    // one stage of absolute differences
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `ME_MACRO_DIM; i++)
        begin
            diff_q[i] <= abs_diff(cur_q.pix[i], ref_q.pix[i]);
        end
    end

    // first tree level adds neighbouring pixels
    always_ff @(posedge clk)
    begin
        for (int p = 0; p < PAIRS; p++)
        begin
            pair_q[p] <= sad_t'(diff_q[2*p]) + sad_t'(diff_q[2*p+1]);
        end
    end

    always_ff @(posedge clk)
    begin
        row_sum <= pair_q[0] + pair_q[1];
    end

    // a new row may enter on any cycle so the tag moves with every stage
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            in_valid      <= 1'b0;
            diff_valid    <= 1'b0;
            pair_valid    <= 1'b0;
            row_sum_valid <= 1'b0;
        end
        else
        begin
            in_valid      <= en_cpr;
            diff_valid    <= in_valid;
            pair_valid    <= diff_valid;
            row_sum_valid <= pair_valid;
        end
    end

    // both row registers are loaded together or the pixels get paired wrongly
    a_enables_match: assert property (@(posedge clk) disable iff (!rst_n)
        en_cpr == en_spr);

endmodule

`default_nettype wire

// File: sad_accum_min.sv
`timescale 1ns/1ps
`default_nettype none

`include "me_consts.svh"

module sad_accum_min
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              acc_clear,
    input  logic              best_clear,
    input  logic              valid,
    input  logic              row_sum_valid,
    input  me_pkg::sad_t      row_sum,
    output me_pkg::me_result_t result
);

    import me_pkg::*;

    sad_t                  acc;
    me_result_t            result_q;
    me_result_t            result_next;
    logic                  have_best;   // no best exists yet after reset
    logic [`ME_CAND_W-1:0] cand_idx;
    logic [`ME_CAND_W-1:0] run_idx;
    logic                  take;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            acc <= '0;
        end
        else if (acc_clear)
        begin
            acc <= '0;
        end
        else if (row_sum_valid)
        begin
            acc <= acc + row_sum;
        end
    end

    always_comb
    begin
        run_idx = best_clear ? '0 : cand_idx;
        take    = best_clear || !have_best || (acc < result_q.best_sad);   // ties keep the older index
        result_next.sad      = acc;
        result_next.best_sad = take ? acc : result_q.best_sad;
        result_next.best_idx = take ? run_idx : result_q.best_idx;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            result_q  <= '0;
            have_best <= 1'b0;
            cand_idx  <= '0;
        end
        else if (valid)
        begin
            result_q  <= result_next;
            have_best <= 1'b1;
            cand_idx  <= run_idx + 1'b1;
        end
    end

    // the fresh value shows during the done cycle and is held afterwards
    assign result = valid ? result_next : result_q;

    // the last row sum has to land before the block is finalized
    a_no_late_row: assert property (@(posedge clk) disable iff (!rst_n)
        !(row_sum_valid && valid));

endmodule

`default_nettype wire

// File: me_top.sv
`timescale 1ns/1ps
`default_nettype none

module me_top
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              clear_best,
    input  me_pkg::pixel_row_t cur_row,
    input  me_pkg::pixel_row_t ref_row,
    output logic              row_ready,
    output logic              done,
    output me_pkg::me_result_t result
);

    import me_pkg::*;

    logic en_cpr;
    logic en_spr;
    logic acc_clear;
    logic valid;
    logic best_clear;
    sad_t row_sum;
    logic row_sum_valid;

    controller_me i_controller
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .clear_best (clear_best),
        .en_cpr     (en_cpr),
        .en_spr     (en_spr),
        .acc_clear  (acc_clear),
        .valid      (valid),
        .best_clear (best_clear)
    );

    sad_row_tree i_row_tree
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .en_cpr        (en_cpr),
        .en_spr        (en_spr),
        .cur_row       (cur_row),
        .ref_row       (ref_row),
        .row_sum       (row_sum),
        .row_sum_valid (row_sum_valid)
    );

    sad_accum_min i_accum
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .acc_clear     (acc_clear),
        .best_clear    (best_clear),
        .valid         (valid),
        .row_sum_valid (row_sum_valid),
        .row_sum       (row_sum),
        .result        (result)
    );

    assign row_ready = en_cpr;   // the caller presents a row whenever the tree loads one
    assign done      = valid;

endmodule

`default_nettype wire

// File: me_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "me_consts.svh"

module me_checker
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               clear_best,
    input  me_pkg::pixel_row_t cur_row,
    input  me_pkg::pixel_row_t ref_row,
    input  logic               row_ready,
    input  logic               done,
    input  me_pkg::me_result_t result,
    input  logic [8*12-1:0]    test_name,
    output int                 error_count,
    output int                 tests_seen
);

    import me_pkg::*;

    localparam int DONE_AT = `ME_MACRO_DIM + `ME_PIPE_DEPTH + 1;   // cycles from start to done

    logic            busy = 1'b0;
    logic            have_best = 1'b0;
    logic            run_clear;
    logic            test_bad;
    logic [8*12-1:0] run_name;
    int              errors = 0;
    int              finished = 0;
    int              age;
    int              rows;
    int              sum;
    int              best_sad;
    int              best_idx;
    int              next_idx = 0;

    assign error_count = errors;
    assign tests_seen  = finished;

    function automatic int row_sad(input pixel_row_t a, input pixel_row_t b);
        int s;
        int d;
        s = 0;
        for (int i = 0; i < `ME_MACRO_DIM; i++)
        begin
            d = int'(a.pix[i]) - int'(b.pix[i]);
            s += (d < 0) ? -d : d;
        end
        return s;
    endfunction

    task automatic compare(input string field, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("CHECK FAILED %0s %0s: expected %0d, actual %0d",
                     run_name, field, expected, actual);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic finish_run;
        int cand;
        if (age != DONE_AT || rows != `ME_MACRO_DIM)
        begin
            $display("%0s: done came %0d cycles after start with %0d rows loaded",
                     run_name, age, rows);
            errors++;
            test_bad = 1'b1;
        end
        cand = run_clear ? 0 : next_idx;
        if (run_clear || !have_best || sum < best_sad)
        begin
            best_sad = sum;
            best_idx = cand;
        end
        have_best = 1'b1;
        next_idx  = (cand + 1) % (1 << `ME_CAND_W);
        compare("sad", sum, int'(result.sad));
        compare("best_sad", best_sad, int'(result.best_sad));
        compare("best_idx", best_idx, int'(result.best_idx));
        $display("test %0s %0s", run_name, test_bad ? "failed" : "ok");
        finished++;
        busy = 1'b0;
    endtask

    // inputs change just after the rising edge, so the falling edge sees settled values
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            if (row_ready || done || result != '0)
            begin
                $display("outputs are not idle and zero while reset is held");
                errors++;
            end
        end
        else
        begin
            if (busy)
            begin
                age++;
            end
            if (start && !busy)
            begin
                busy      = 1'b1;
                run_clear = clear_best;
                run_name  = test_name;
                test_bad  = 1'b0;
                age       = 0;
                rows      = 0;
                sum       = 0;
            end
            if (row_ready)
            begin
                if (!busy || age < 1 || age > `ME_MACRO_DIM)
                begin
                    $display("row_ready is high outside the row window of %0s", run_name);
                    errors++;
                    test_bad = 1'b1;
                end
                rows++;
                sum += row_sad(cur_row, ref_row);
            end
            if (done && !busy)
            begin
                $display("done pulsed with no run in progress after %0s", run_name);
                errors++;
            end
            else if (done)
            begin
                finish_run();
            end
            else if (busy && age > DONE_AT)
            begin
                $display("no done seen for %0s within %0d cycles", run_name, DONE_AT);
                errors++;
                busy = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_me_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "me_consts.svh"

module tb_me_top;

    import me_pkg::*;

    localparam int DIM        = `ME_MACRO_DIM;
    localparam int N_DIRECTED = 10;
    localparam int N_RANDOM   = 6;
    localparam int N_TESTS    = N_DIRECTED + N_RANDOM;
    localparam int MAX_CYCLES = N_TESTS * 15 + 20;

    logic            clk;
    logic            rst_n;
    logic            start;
    logic            clear_best;
    pixel_row_t      cur_row;
    pixel_row_t      ref_row;
    logic            row_ready;
    logic            done;
    me_result_t      result;
    logic [8*12-1:0] test_name;
    int              error_count;
    int              tests_seen;
    int              cycles = 0;
    int              seed;

    logic [8*12-1:0] name_tab [N_TESTS];
    logic            clear_tab [N_TESTS];
    logic            busy_tab [N_TESTS];   // issue a second start while the run is busy
    pixel_row_t      cur_tab [N_TESTS][DIM];
    pixel_row_t      ref_tab [N_TESTS][DIM];

    me_top i_me_top
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .clear_best (clear_best),
        .cur_row    (cur_row),
        .ref_row    (ref_row),
        .row_ready  (row_ready),
        .done       (done),
        .result     (result)
    );

    me_checker i_checker
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .clear_best  (clear_best),
        .cur_row     (cur_row),
        .ref_row     (ref_row),
        .row_ready   (row_ready),
        .done        (done),
        .result      (result),
        .test_name   (test_name),
        .error_count (error_count),
        .tests_seen  (tests_seen)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // spreads the wanted SAD evenly over the 16 pixels, alternating the sign
    task automatic add_directed(input int e, input logic [8*12-1:0] name, input logic clr,
                                input logic busy, input int target);
        int d;
        int base;
        name_tab[e]  = name;
        clear_tab[e] = clr;
        busy_tab[e]  = busy;
        for (int k = 0; k < DIM * DIM; k++)
        begin
            d    = target / (DIM * DIM) + ((k < target % (DIM * DIM)) ? 1 : 0);
            base = 64 + 9 * k + e;
            cur_tab[e][k / DIM].pix[k % DIM] = pixel_t'(base);
            ref_tab[e][k / DIM].pix[k % DIM] = pixel_t'((k % 2 == 1) ? base + d : base - d);
        end
    endtask

    task automatic add_random(input int e);
        name_tab[e]  = {"random_", 8'h30 + 8'(e - N_DIRECTED)};
        clear_tab[e] = 1'b0;
        busy_tab[e]  = 1'b0;
        for (int k = 0; k < DIM * DIM; k++)
        begin
            cur_tab[e][k / DIM].pix[k % DIM] = pixel_t'($random(seed));
            ref_tab[e][k / DIM].pix[k % DIM] = pixel_t'($random(seed));
        end
    endtask

    task automatic run_test(input int e);
        int r;
        test_name  = name_tab[e];
        start      = 1'b1;
        clear_best = clear_tab[e];
        @(posedge clk);
        #1;
        start      = 1'b0;
        clear_best = 1'b0;
        r = 0;
        while (r < DIM)
        begin
            if (row_ready)
            begin
                cur_row    = cur_tab[e][r];
                ref_row    = ref_tab[e][r];
                start      = busy_tab[e] && (r == 2);   // must be ignored by the busy engine
                clear_best = start;
                r++;
            end
            @(posedge clk);
            #1;
        end
        start      = 1'b0;
        clear_best = 1'b0;
        while (!done)
        begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    initial
    begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        clear_best = 1'b0;
        cur_row    = '0;
        ref_row    = '0;
        test_name  = '0;
        seed       = 68;
        add_directed(0, "identical", 1'b1, 1'b0, 0);
        add_directed(1, "max_diff", 1'b0, 1'b0, 0);
        for (int k = 0; k < DIM * DIM; k++)
        begin
            cur_tab[1][k / DIM].pix[k % DIM] = 8'd255;
            ref_tab[1][k / DIM].pix[k % DIM] = 8'd0;
        end
        add_directed(2, "track_first", 1'b1, 1'b0, 100);
        add_directed(3, "track_lower", 1'b0, 1'b0, 60);
        add_directed(4, "track_equal", 1'b0, 1'b0, 60);   // ties keep the earlier index
        add_directed(5, "track_higher", 1'b0, 1'b0, 200);
        add_directed(6, "track_lowest", 1'b0, 1'b0, 10);
        add_directed(7, "clear_mid", 1'b1, 1'b0, 500);
        add_directed(8, "after_clear", 1'b0, 1'b0, 300);
        add_directed(9, "busy_start", 1'b0, 1'b1, 700);
        for (int e = N_DIRECTED; e < N_TESTS; e++)
        begin
            add_random(e);
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int e = 0; e < N_TESTS; e++)
        begin
            run_test(e);
        end
        repeat (2) @(posedge clk);
        $display("tests finished %0d of %0d, errors %0d", tests_seen, N_TESTS, error_count);
        if (error_count == 0 && tests_seen == N_TESTS)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: me_top.f
+incdir+.
me_pkg.sv
controller_me.sv
sad_row_tree.sv
sad_accum_min.sv
me_top.sv
me_checker.sv
tb_me_top.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_me_top
RTL_TOP    ?= me_top
FILELIST   ?= me_top.f
RTL_SRCS   ?= me_pkg.sv controller_me.sv sad_row_tree.sv sad_accum_min.sv me_top.sv
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall +incdir+.
SIM_FLAGS  ?= --binary --timing --assert
PASS_TEXT  ?= >>> PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
